// ==== filelist.f ====
source/sd_pkg.sv
source/sd_sck_gen.sv
source/sd_spi_engine.sv
source/sd_block_buffer.sv
source/sd_bus_regs.sv
source/sd_spi_top.sv
tests/sd_card_model.sv
tests/sd_spi_tb.sv

// ==== Bender.yml ====
package:
  name: sd_spi

sources:
  - source/sd_pkg.sv
  - source/sd_sck_gen.sv
  - source/sd_spi_engine.sv
  - source/sd_block_buffer.sv
  - source/sd_bus_regs.sv
  - source/sd_spi_top.sv
  - target: test
    files:
      - tests/sd_card_model.sv
      - tests/sd_spi_tb.sv

// ==== tests/sd_spi_tb.sv ====
`timescale 1ns/1ps

module sd_spi_tb
  import sd_pkg::*;
();

  localparam int SEED          = 27691;
  localparam int CLK_NS        = 10;
  localparam int REG_ACK_EDGES = 2;
  // worst case block read after a full token hunt, in clock cycles
  localparam int XFER_CYCLES   = (CMD_BITS + TOKEN_TIMEOUT + (BLOCK_BYTES + CRC_BYTES + 16) * 8)
                                 * SCK_DIV;
  // room for about eight of those, a little over 3 ms
  localparam int WATCHDOG_NS   = 8 * XFER_CYCLES * CLK_NS;

  logic        clk;
  logic        rst;
  bus_req_t    bus_req;
  bus_rsp_t    bus_rsp;
  logic        sck;
  logic        mosi;
  logic        cs;
  logic        miso;
  int          errors = 0;
  logic [7:0]  blk [BLOCK_BYTES];

  sd_spi_top u_sd_spi_top (
    .clk       (clk),
    .rst       (rst),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp),
    .sck_o     (sck),
    .mosi_o    (mosi),
    .cs_o      (cs),
    .miso_i    (miso)
  );

  sd_card_model u_sd_card_model (
    .sck_i  (sck),
    .mosi_i (mosi),
    .cs_i   (cs),
    .miso_o (miso)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(CLK_NS / 2) clk = ~clk;
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("Something failed");
    $finish;
  end

  function automatic logic [31:0] lane_mask(input logic [3:0] sel);
    return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
  endfunction

  // register byte 0 shows up in bus bits 31:24
  function automatic logic [31:0] swap_mask(input logic [31:0] r, input logic [3:0] sel);
    return {r[7:0], r[15:8], r[23:16], r[31:24]} & lane_mask(sel);
  endfunction

  function automatic logic [31:0] merge_write(input logic [31:0] r, input logic [31:0] d,
                                              input logic [3:0] sel);
    logic [31:0] m;
    m = {{8{sel[0]}}, {8{sel[1]}}, {8{sel[2]}}, {8{sel[3]}}};
    return (r & ~m) | ({d[7:0], d[15:8], d[23:16], d[31:24]} & m);
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected)
    else
    begin
      errors++;
      $display("FAILED %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // called on a rising edge, returns one idle cycle after ack
  task automatic bus_xfer(input logic we, input logic [29:0] adr, input logic [3:0] sel,
                          input logic [31:0] wdat, input int max_edges,
                          output logic [31:0] rdat, output int edges);
    bus_req_t r;
    r.cyc = 1'b1;
    r.stb = 1'b1;
    r.we  = we;
    r.adr = adr;
    r.sel = sel;
    r.dat = wdat;
    bus_req <= r;
    edges = 0;
    do
    begin
      @(posedge clk);
      edges++;
    end
    while (!bus_rsp.ack && edges < max_edges);
    rdat = bus_rsp.dat;
    if (!bus_rsp.ack)
    begin
      errors++;
      $display("no ack for address %h after %0d cycles", adr, edges);
    end
    bus_req <= '0;
    @(posedge clk);
  endtask

  task automatic bus_write(input logic [29:0] adr, input logic [3:0] sel,
                           input logic [31:0] dat);
    logic [31:0] rdat;
    int          edges;
    bus_xfer(1'b1, adr, sel, dat, 16, rdat, edges);
    check_value("write ack latency", REG_ACK_EDGES, edges);
  endtask

  task automatic bus_read(input logic [29:0] adr, input logic [3:0] sel,
                          output logic [31:0] rdat);
    int edges;
    bus_xfer(1'b0, adr, sel, 32'h0, 16, rdat, edges);
    check_value("read ack latency", REG_ACK_EDGES, edges);
  endtask

  task automatic load_byte(inout int pos, input logic [7:0] b);
    u_sd_card_model.tx_mem[pos] = b;
    pos++;
  endtask

  task automatic test_reset_decode();
    logic [31:0] rdat;
    check_value("cs_o", 1, cs);
    check_value("sck_o", 0, sck);
    repeat (20)
    begin
      @(posedge clk);
      check_value("ack", 0, bus_rsp.ack);
    end
    bus_read(ADR_STATUS, 4'hF, rdat);
    check_value("status", 0, rdat);
    bus_write(ADR_NOOP, 4'hF, $urandom);
    bus_read(ADR_NOOP, 4'hF, rdat);
    check_value("noop data", 0, rdat);
    bus_write(30'h40, 4'hF, $urandom);
    bus_read(30'h40, 4'hF, rdat);
    check_value("unmapped data", 0, rdat);
    bus_read(30'h07, 4'hF, rdat);
    check_value("unmapped data", 0, rdat);
  endtask

  task automatic test_registers();
    logic [31:0] model [2];
    logic [31:0] rdat;
    logic [31:0] wdat;
    logic [3:0]  wsel;
    logic [3:0]  rsel;
    int          k;
    int          i;
    model[0] = '0;
    model[1] = '0;
    for (i = 0; i < 16; i++)
    begin
      k    = $urandom_range(1);
      wsel = $urandom;
      rsel = $urandom;
      wdat = $urandom;
      bus_write(ADR_CMD_LO + k, wsel, wdat);
      model[k] = merge_write(model[k], wdat, wsel);
      bus_read(ADR_CMD_LO + k, rsel, rdat);
      check_value("cmd readback", swap_mask(model[k], rsel), rdat);
    end
  endtask

  task automatic run_command(input logic capture, input int len, input logic with_token);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [63:0] cmd;
    logic [47:0] rsp_exp;
    logic [7:0]  b;
    logic [2:0]  st_exp;
    logic [31:0] rdat;
    logic [3:0]  sel;
    int          pos;
    int          edges;
    int          i;
    r0  = $urandom;
    r1  = $urandom;
    cmd = {capture, 7'(len), r1[23:16], r1[15:0], r0};
    bus_write(ADR_CMD_LO, 4'hF, swap_mask(cmd[31:0], 4'hF));
    bus_write(ADR_CMD_HI, 4'hF, swap_mask(cmd[63:32], 4'hF));

    pos = 0;
    repeat (1 + $urandom_range(7)) load_byte(pos, 8'hFF);
    rsp_exp = '0;
    for (i = 0; i < len; i++)
    begin
      b = $urandom;
      if (i == 0)
      begin
        b[7] = 1'b0;
      end
      rsp_exp = {rsp_exp[39:0], b};
      load_byte(pos, b);
    end
    if (capture && with_token)
    begin
      repeat (1 + $urandom_range(7)) load_byte(pos, 8'hFF);
      load_byte(pos, START_TOKEN);
      for (i = 0; i < BLOCK_BYTES; i++)
      begin
        blk[i] = $urandom;
        load_byte(pos, blk[i]);
      end
      // crc bytes
      repeat (CRC_BYTES) load_byte(pos, $urandom);
    end
    u_sd_card_model.tx_len = pos;

    bus_xfer(1'b1, ADR_SEND, 4'hF, 32'h0, 2 * XFER_CYCLES, rdat, edges);
    check_value("mosi frame", cmd[47:0], u_sd_card_model.rx_frame);
    check_value("cs_o", 1, cs);
    st_exp = {capture && !with_token, capture && with_token, 1'b1};
    bus_read(ADR_STATUS, 4'hF, rdat);
    check_value("status", swap_mask({29'b0, st_exp}, 4'hF), rdat);
    bus_read(ADR_RSP_LO, 4'hF, rdat);
    check_value("rsp_lo", swap_mask(rsp_exp[31:0], 4'hF), rdat);
    bus_read(ADR_RSP_HI, 4'hF, rdat);
    check_value("rsp_hi", swap_mask({16'h0000, rsp_exp[47:32]}, 4'hF), rdat);

    if (capture && with_token)
    begin
      for (i = 0; i < DATA_WORDS; i++)
      begin
        sel = (i % 4 == 0) ? 4'($urandom) : 4'hF;
        bus_read(ADR_DATA_BASE + i, sel, rdat);
        check_value("data word",
                    {blk[4*i+3], blk[4*i+2], blk[4*i+1], blk[4*i]} & lane_mask(sel), rdat);
      end
    end
  endtask

  a_mosi_sck_low: assert property (@(posedge clk) disable iff (rst)
    $changed(mosi) |-> !sck)
    else
    begin
      errors++;
      $display("mosi changed while sck was high");
    end

  a_sck_running: assert property (@(posedge clk) disable iff (rst)
    $rose(sck) |-> ##SCK_DIV $rose(sck))
    else
    begin
      errors++;
      $display("sck stopped toggling at its period");
    end

  // cs rises only once the whole frame went out and the card stream is used up
  a_cs_span: assert property (@(posedge clk) disable iff (rst)
    (!$past(cs) && cs) |-> (u_sd_card_model.tx_done && u_sd_card_model.rx_cnt == 48))
    else
    begin
      errors++;
      $display("cs went high before the transfer was complete");
    end

  a_ack_with_req: assert property (@(posedge clk) disable iff (rst)
    bus_rsp.ack |-> (bus_req.cyc && bus_req.stb))
    else
    begin
      errors++;
      $display("ack appeared without a bus request");
    end

  initial
  begin
    void'($urandom(SEED));
    rst     = 1'b1;
    bus_req = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    test_reset_decode();
    test_registers();
    run_command(1'b0, 1, 1'b0);
    run_command(1'b0, 5, 1'b0);
    run_command(1'b1, 1 + $urandom_range(5), 1'b1);
    run_command(1'b1, 2, 1'b0);
    repeat (10) @(posedge clk);
    $display("errors counted: %0d", errors);
    if (errors == 0)
    begin
      $display("Everything OK");
    end
    else
    begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== tests/sd_card_model.sv ====
`timescale 1ns/1ps

module sd_card_model (
  input  logic sck_i,
  input  logic mosi_i,
  input  logic cs_i,
  output logic miso_o
);

  // bytes returned after the command frame, loaded by the testbench
  logic [7:0]  tx_mem [1024];
  int          tx_len;
  int          tx_pos;
  int          rx_cnt;
  logic [47:0] rx_frame;
  logic        tx_done;

  assign tx_done = (tx_pos >= tx_len * 8);

  initial
  begin
    miso_o   = 1'b1;
    tx_len   = 0;
    tx_pos   = 0;
    rx_cnt   = 0;
    rx_frame = '0;
  end

  // new transfer
  always @(negedge cs_i)
  begin
    tx_pos = 0;
    rx_cnt = 0;
  end

  always @(posedge cs_i)
  begin
    miso_o = 1'b1;
  end

  always @(posedge sck_i)
  begin
    if (cs_i == 1'b0 && rx_cnt < 48)
    begin
      rx_frame = {rx_frame[46:0], mosi_i};
      rx_cnt   = rx_cnt + 1;
    end
  end

  // next bit after the falling edge, idle high once the stream runs out
  always @(negedge sck_i)
  begin
    if (cs_i == 1'b0 && rx_cnt == 48)
    begin
      if (tx_pos < tx_len * 8)
      begin
        miso_o = tx_mem[tx_pos / 8][7 - tx_pos % 8];
        tx_pos = tx_pos + 1;
      end
      else
      begin
        miso_o = 1'b1;
      end
    end
  end

endmodule

// ==== source/sd_spi_top.sv ====
`timescale 1ns/1ps

module sd_spi_top
  import sd_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  bus_req_t bus_req_i,
  output bus_rsp_t bus_rsp_o,
  output logic     sck_o,
  output logic     mosi_o,
  output logic     cs_o,
  input  logic     miso_i
);

  logic        start;
  cmd_t        cmd;
  sd_result_t  result;
  logic        bit_step;
  buf_wr_t     buf_wr;
  logic [6:0]  buf_rd_word;
  logic [31:0] buf_rd_data;

  sd_bus_regs u_sd_bus_regs (
    .clk           (clk),
    .rst           (rst),
    .bus_req_i     (bus_req_i),
    .bus_rsp_o     (bus_rsp_o),
    .start_o       (start),
    .cmd_o         (cmd),
    .result_i      (result),
    .buf_rd_word_o (buf_rd_word),
    .buf_rd_data_i (buf_rd_data)
  );

  sd_sck_gen u_sd_sck_gen (
    .clk        (clk),
    .rst        (rst),
    .sck_o      (sck_o),
    .bit_step_o (bit_step)
  );

  sd_spi_engine u_sd_spi_engine (
    .clk        (clk),
    .rst        (rst),
    .start_i    (start),
    .cmd_i      (cmd),
    .bit_step_i (bit_step),
    .miso_i     (miso_i),
    .mosi_o     (mosi_o),
    .cs_o       (cs_o),
    .result_o   (result),
    .buf_wr_o   (buf_wr)
  );

  sd_block_buffer u_sd_block_buffer (
    .clk       (clk),
    .rst       (rst),
    .wr_i      (buf_wr),
    .rd_word_i (buf_rd_word),
    .rd_data_o (buf_rd_data)
  );

endmodule

// ==== source/sd_bus_regs.sv ====
`timescale 1ns/1ps

module sd_bus_regs
  import sd_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  bus_req_t    bus_req_i,
  output bus_rsp_t    bus_rsp_o,
  output logic        start_o,
  output cmd_t        cmd_o,
  input  sd_result_t  result_i,
  output logic [6:0]  buf_rd_word_o,
  input  logic [31:0] buf_rd_data_i
);

  cmd_t                    cmd_q;
  logic [2:0]              status_q;
  logic [RSP_MAX_BITS-1:0] rsp_q;
  logic                    ack_q;
  logic                    send_pend;
  logic                    rd_buf_q;
  logic [3:0]              sel_q;
  logic [31:0]             rdata_q;
  logic [31:0]             buf_mask;
  logic                    accept;
  logic                    in_window;

  // bus lane j carries register byte 3-j
  function automatic logic [31:0] rd_lanes(input logic [31:0] r, input logic [3:0] sel);
    logic [31:0] d;
    for (int j = 0; j < 4; j++)
    begin
      d[8*j +: 8] = sel[j] ? r[8*(3-j) +: 8] : 8'h00;
    end
    return d;
  endfunction

  function automatic logic [31:0] wr_lanes(input logic [31:0] r, input logic [31:0] d,
                                           input logic [3:0] sel);
    logic [31:0] n;
    n = r;
    for (int j = 0; j < 4; j++)
    begin
      if (sel[j])
      begin
        n[8*(3-j) +: 8] = d[8*j +: 8];
      end
    end
    return n;
  endfunction

  always_comb
  begin
    accept        = bus_req_i.cyc && bus_req_i.stb && !ack_q && !send_pend;
    in_window     = (bus_req_i.adr >= ADR_DATA_BASE) &&
                    (bus_req_i.adr < ADR_DATA_BASE + DATA_WORDS);
    buf_rd_word_o = 7'(bus_req_i.adr - ADR_DATA_BASE);
    for (int j = 0; j < 4; j++)
    begin
      buf_mask[8*j +: 8] = {8{sel_q[j]}};
    end
    // buffer data arrives registered, in step with ack
    bus_rsp_o.ack = ack_q;
    bus_rsp_o.dat = rd_buf_q ? (buf_rd_data_i & buf_mask) : rdata_q;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ack_q     <= 1'b0;
      send_pend <= 1'b0;
      start_o   <= 1'b0;
      rd_buf_q  <= 1'b0;
      cmd_q     <= '0;
      status_q  <= '0;
      rsp_q     <= '0;
    end
    else
    begin
      ack_q    <= 1'b0;
      start_o  <= 1'b0;
      rd_buf_q <= 1'b0;
      rdata_q  <= '0;
      if (send_pend && result_i.done)
      begin
        // send ack trails done by one cycle
        ack_q     <= 1'b1;
        send_pend <= 1'b0;
        status_q  <= {result_i.timeout, result_i.data_valid, result_i.rsp_valid};
        rsp_q     <= result_i.rsp;
      end
      else if (accept)
      begin
        ack_q <= 1'b1;
        sel_q <= bus_req_i.sel;
        if (in_window)
        begin
          rd_buf_q <= 1'b1;
        end
        else
        begin
          case (bus_req_i.adr)
            ADR_NOOP:
            begin
              rdata_q <= '0;
            end
            ADR_SEND:
            begin
              if (bus_req_i.we)
              begin
                ack_q     <= 1'b0;
                send_pend <= 1'b1;
                start_o   <= 1'b1;
                cmd_o     <= cmd_q;
                status_q  <= '0;
                rsp_q     <= '0;
              end
            end
            ADR_CMD_LO:
            begin
              if (bus_req_i.we)
              begin
                cmd_q[31:0] <= wr_lanes(cmd_q[31:0], bus_req_i.dat, bus_req_i.sel);
              end
              rdata_q <= rd_lanes(cmd_q[31:0], bus_req_i.sel);
            end
            ADR_CMD_HI:
            begin
              if (bus_req_i.we)
              begin
                cmd_q[63:32] <= wr_lanes(cmd_q[63:32], bus_req_i.dat, bus_req_i.sel);
              end
              rdata_q <= rd_lanes(cmd_q[63:32], bus_req_i.sel);
            end
            // bit 0 lands on bus bit 24 after lane reversal
            ADR_STATUS:
            begin
              rdata_q <= rd_lanes({29'b0, status_q}, bus_req_i.sel);
            end
            ADR_RSP_LO:
            begin
              rdata_q <= rd_lanes(rsp_q[31:0], bus_req_i.sel);
            end
            ADR_RSP_HI:
            begin
              rdata_q <= rd_lanes({16'h0000, rsp_q[47:32]}, bus_req_i.sel);
            end
            default:
            begin
              rdata_q <= '0;
            end
          endcase
        end
      end
    end
  end

  a_ack_pulse: assert property (@(posedge clk) disable iff (rst)
    ack_q |=> !ack_q)
    else $error("ack held for more than one cycle");

endmodule

// ==== source/sd_block_buffer.sv ====
`timescale 1ns/1ps

module sd_block_buffer
  import sd_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  buf_wr_t     wr_i,
  input  logic [6:0]  rd_word_i,
  output logic [31:0] rd_data_o
);

  logic [$clog2(BLOCK_BYTES):0] wr_idx;
  logic                         wr_en;

  // index parks at the block size, trailing bytes fall away
  always_comb
  begin
    wr_en = wr_i.valid && (wr_idx < BLOCK_BYTES);
  end

  always_ff @(posedge clk)
  begin
    if (rst || wr_i.block_start)
    begin
      wr_idx <= '0;
    end
    else if (wr_en)
    begin
      wr_idx <= wr_idx + 1'b1;
    end
  end

  // lane l holds bytes 4n+l
  for (genvar l = 0; l < 4; l++)
  begin : g_lane
    logic [7:0] mem [DATA_WORDS];

    always_ff @(posedge clk)
    begin
      if (wr_en && (wr_idx[1:0] == 2'(l)))
      begin
        mem[wr_idx[$clog2(BLOCK_BYTES)-1:2]] <= wr_i.data;
      end
      rd_data_o[8*l +: 8] <= mem[rd_word_i];
    end
  end

  a_wr_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(wr_i.block_start && wr_i.valid))
    else $error("block_start and valid in the same cycle");

endmodule

// ==== source/sd_spi_engine.sv ====
`timescale 1ns/1ps

module sd_spi_engine
  import sd_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       start_i,
  input  cmd_t       cmd_i,
  input  logic       bit_step_i,
  input  logic       miso_i,
  output logic       mosi_o,
  output logic       cs_o,
  output sd_result_t result_o,
  output buf_wr_t    buf_wr_o
);

  typedef enum logic [5:0] {
    S_IDLE  = 6'b000001,
    S_CMD   = 6'b000010,
    S_HUNT  = 6'b000100,
    S_RSP   = 6'b001000,
    S_TOKEN = 6'b010000,
    S_DATA  = 6'b100000
  } state_t;

  state_t                  state;
  logic [12:0]             bit_cnt;
  logic [12:0]             rsp_last;
  logic [7:0]              sh8;
  logic [7:0]              sh8_nxt;
  logic [RSP_MAX_BITS-1:0] rsp_sr;
  logic                    done_q;
  logic                    rsp_valid_q;
  logic                    data_valid_q;
  logic                    timeout_q;

  always_comb
  begin
    rsp_last = {3'b000, cmd_i.rsp_len, 3'b000} - 13'd1;
    sh8_nxt  = {sh8[6:0], miso_i};

    result_o.done       = done_q;
    result_o.rsp_valid  = rsp_valid_q;
    result_o.data_valid = data_valid_q;
    result_o.timeout    = timeout_q;
    result_o.rsp        = rsp_sr;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state                <= S_IDLE;
      bit_cnt              <= '0;
      cs_o                 <= 1'b1;
      mosi_o               <= 1'b1;
      done_q               <= 1'b0;
      rsp_valid_q          <= 1'b0;
      data_valid_q         <= 1'b0;
      timeout_q            <= 1'b0;
      buf_wr_o.block_start <= 1'b0;
      buf_wr_o.valid       <= 1'b0;
    end
    else
    begin
      done_q               <= 1'b0;
      buf_wr_o.block_start <= 1'b0;
      buf_wr_o.valid       <= 1'b0;

      case (state)
        S_IDLE:
        begin
          if (start_i)
          begin
            state        <= S_CMD;
            bit_cnt      <= 13'(CMD_BITS - 1);
            rsp_valid_q  <= 1'b0;
            data_valid_q <= 1'b0;
            timeout_q    <= 1'b0;
          end
        end
        S_CMD:
        begin
          // cs drops together with the first frame bit
          if (bit_step_i)
          begin
            cs_o   <= 1'b0;
            mosi_o <= cmd_i.frame[bit_cnt[5:0]];
            if (bit_cnt == '0)
            begin
              state <= S_HUNT;
            end
            else
            begin
              bit_cnt <= bit_cnt - 13'd1;
            end
          end
        end
        S_HUNT:
        begin
          if (bit_step_i)
          begin
            mosi_o <= 1'b1;
            // start bit counts as response bit one
            if (!miso_i)
            begin
              rsp_sr  <= '0;
              bit_cnt <= 13'd1;
              state   <= S_RSP;
            end
          end
        end
        S_RSP:
        begin
          if (bit_step_i)
          begin
            rsp_sr  <= {rsp_sr[RSP_MAX_BITS-2:0], miso_i};
            bit_cnt <= bit_cnt + 13'd1;
            if (bit_cnt == rsp_last)
            begin
              rsp_valid_q <= 1'b1;
              bit_cnt     <= '0;
              if (cmd_i.data_capture)
              begin
                sh8   <= 8'hFF;
                state <= S_TOKEN;
              end
              else
              begin
                cs_o   <= 1'b1;
                done_q <= 1'b1;
                state  <= S_IDLE;
              end
            end
          end
        end
        S_TOKEN:
        begin
          if (bit_step_i)
          begin
            sh8     <= sh8_nxt;
            bit_cnt <= bit_cnt + 13'd1;
            if (sh8_nxt == START_TOKEN)
            begin
              bit_cnt              <= '0;
              buf_wr_o.block_start <= 1'b1;
              state                <= S_DATA;
            end
            else if (bit_cnt == 13'(TOKEN_TIMEOUT - 1))
            begin
              timeout_q <= 1'b1;
              cs_o      <= 1'b1;
              done_q    <= 1'b1;
              state     <= S_IDLE;
            end
          end
        end
        S_DATA:
        begin
          if (bit_step_i)
          begin
            sh8     <= sh8_nxt;
            bit_cnt <= bit_cnt + 13'd1;
            if (bit_cnt[2:0] == 3'd7)
            begin
              buf_wr_o.valid <= 1'b1;
              buf_wr_o.data  <= sh8_nxt;
            end
            // block plus crc, the buffer drops the crc bytes
            if (bit_cnt == 13'((BLOCK_BYTES + CRC_BYTES) * 8 - 1))
            begin
              data_valid_q <= 1'b1;
              cs_o         <= 1'b1;
              done_q       <= 1'b1;
              state        <= S_IDLE;
            end
          end
        end
        default:
        begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  a_start_idle: assert property (@(posedge clk) disable iff (rst)
    start_i |-> state == S_IDLE)
    else $error("start while a transfer is running");

endmodule

// ==== source/sd_sck_gen.sv ====
`timescale 1ns/1ps

module sd_sck_gen
  import sd_pkg::*;
(
  input  logic clk,
  input  logic rst,
  output logic sck_o,
  output logic bit_step_o
);

  logic [$clog2(SCK_DIV)-1:0] cnt;
  logic [$clog2(SCK_DIV)-1:0] cnt_nxt;

  always_comb
  begin
    cnt_nxt = (cnt == SCK_DIV - 1) ? '0 : cnt + 1'b1;
  end

  // step fires at count 0, sck high over the middle half
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      cnt        <= '0;
      sck_o      <= 1'b0;
      bit_step_o <= 1'b0;
    end
    else
    begin
      cnt        <= cnt_nxt;
      bit_step_o <= (cnt == SCK_DIV - 1);
      sck_o      <= (cnt_nxt >= SCK_DIV / 4) && (cnt_nxt < 3 * SCK_DIV / 4);
    end
  end

  a_step_single: assert property (@(posedge clk) disable iff (rst)
    bit_step_o |=> !bit_step_o)
    else $error("bit_step held high for two cycles");

endmodule

// ==== source/sd_pkg.sv ====
package sd_pkg;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [29:0] adr;
    logic [3:0]  sel;
    logic [31:0] dat;
  } bus_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } bus_rsp_t;

  // word addresses
  localparam logic [29:0] ADR_NOOP      = 30'h00;
  localparam logic [29:0] ADR_SEND      = 30'h01;
  localparam logic [29:0] ADR_CMD_LO    = 30'h02;
  localparam logic [29:0] ADR_CMD_HI    = 30'h03;
  localparam logic [29:0] ADR_STATUS    = 30'h04;
  localparam logic [29:0] ADR_RSP_LO    = 30'h05;
  localparam logic [29:0] ADR_RSP_HI    = 30'h06;
  localparam logic [29:0] ADR_DATA_BASE = 30'h80;
  localparam int          DATA_WORDS    = 128;

  localparam int          SCK_DIV       = 8;
  localparam int          CMD_BITS      = 48;
  localparam int          RSP_MAX_BITS  = 48;
  localparam int          BLOCK_BYTES   = 512;
  localparam int          CRC_BYTES     = 2;
  localparam int          TOKEN_TIMEOUT = 512;
  localparam logic [7:0]  START_TOKEN   = 8'hFE;

  // upper byte is flag and length, low 48 bits go out on MOSI
  typedef struct packed {
    logic                data_capture;
    logic [6:0]          rsp_len;
    logic [7:0]          unused;
    logic [CMD_BITS-1:0] frame;
  } cmd_t;

  typedef struct packed {
    logic                    done;
    logic                    rsp_valid;
    logic                    data_valid;
    logic                    timeout;
    logic [RSP_MAX_BITS-1:0] rsp;
  } sd_result_t;

  typedef struct packed {
    logic       block_start;
    logic       valid;
    logic [7:0] data;
  } buf_wr_t;

endpackage
